// File: rtl/dma_arbiter.sv
// ####################
// dma_arbiter
// hold handshake, grants the bus once the cpu status is idle and
// stages the address enables so the bus drivers switch in order
// ####################
`timescale 1ns/10ps

module dma_arbiter (
   input  logic       clk,
   input  logic       reset_n,
   input  logic [2:0] s_n_i,
   input  logic       lock_n_i,
   input  logic       hrq_i,
   output logic       holda_o,
   output logic       aen_brd_o,
   output logic       dma_aen_o
);

   logic bus_idle;
   logic req_q;
   logic holda_q;
   logic aen_brd_q;
   logic dma_aen_q;

   // passive status (all ones) and no locked instruction
   assign bus_idle = (&s_n_i) & lock_n_i;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         req_q     <= 1'b0;
         holda_q   <= 1'b0;
         aen_brd_q <= 1'b0;
         dma_aen_q <= 1'b0;
      end else begin
         req_q <= hrq_i & bus_idle;

         // once granted, hold stays until the request goes away
         holda_q <= hrq_i & (holda_q | req_q);

         aen_brd_q <= holda_q;    // cpu latches off the bus
         dma_aen_q <= aen_brd_q;  // then the dma address drivers on
      end
   end

   assign holda_o   = holda_q;
   assign aen_brd_o = aen_brd_q;
   assign dma_aen_o = dma_aen_q;

endmodule

// File: rtl/io_decode.sv
// ####################
// io_decode
// splits the low i/o port space into 32-port blocks and raises
// the chip select or register write strobe of the addressed block
// ####################
`timescale 1ns/10ps
`include "pc_glue_defines.svh"

module io_decode
   import pc_glue_pkg::*;
(
   input  logic [`PC_IO_ADDR_W-1:0] io_addr_i,
   input  bus_strb_t                bus_i,
   input  logic                     aen_i,
   output io_sel_t                  io_sel_o
);

   logic       dec_en;
   logic [2:0] blk;

   // only ports 000h-0ffh belong to the board, and never during dma
   assign dec_en = ~aen_i && (io_addr_i[`PC_IO_ADDR_W-1:8] == '0);
   assign blk    = io_addr_i[7:5];

   always_comb begin
      io_sel_o = '0;
      if (dec_en) begin
         case (blk)
            `PC_IO_DMA:    io_sel_o.dma  = 1'b1;
            `PC_IO_INTR:   io_sel_o.intr = 1'b1;
            `PC_IO_TC:     io_sel_o.tc   = 1'b1;
            `PC_IO_PPI:    io_sel_o.ppi  = 1'b1;
            // these two are write-only registers on the board
            `PC_IO_DMA_PG: io_sel_o.wr_dma_pg = bus_i.iow;
            `PC_IO_NMI:    io_sel_o.wr_nmi    = bus_i.iow;
            default:       io_sel_o = '0;  // blocks 6 and 7 unused
         endcase
      end
   end

endmodule

// File: rtl/mem_decode.sv
// ####################
// mem_decode
// rom socket selects, ram bank select and the ras, address select,
// cas sequence for the dynamic ram, refresh included
// ####################
`timescale 1ns/10ps
`include "pc_glue_defines.svh"

module mem_decode
   import pc_glue_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset_n,
   input  logic [`PC_ADDR_W-1:0]   addr_i,
   input  bus_strb_t               bus_i,
   input  logic                    dack0_i,
   output logic [`PC_ROM_SELS-1:0] rom_cs_n_o,
   output logic                    ram_sel_o,
   output ram_strb_t               ram_strb_o
);

   localparam int CNT_W = $clog2(`PC_CAS_DELAY + 1);

   logic                     rom_sel;
   logic                     mem_cmd;
   logic                     refresh;
   logic                     start;
   logic [`PC_RAM_BANKS-1:0] bank_oh;
   logic [`PC_RAM_BANKS-1:0] ras_q;
   logic [`PC_RAM_BANKS-1:0] cas_q;
   logic                     asel_q;
   logic [CNT_W-1:0]         cnt_q;   // cycles since ras rose
   logic                     busy;
   logic                     ref_cyc;

   // rom lives in the top 64k segment
   assign rom_sel = &addr_i[19:16];

   always_comb begin
      rom_cs_n_o = '1;
      if (rom_sel && bus_i.memr)
         rom_cs_n_o = ~(`PC_ROM_SELS'(1) << addr_i[15:13]);
   end

   // ram is the low 256k, refresh dma cycles excluded
   assign ram_sel_o = (addr_i[19:18] == 2'b00) && ~dack0_i;
   assign bank_oh   = `PC_RAM_BANKS'(1) << addr_i[17:16];

   assign mem_cmd = bus_i.memr | bus_i.memw;
   assign refresh = bus_i.memr & dack0_i;  // dma channel 0 read
   assign start   = mem_cmd && (ram_sel_o || refresh);

   assign busy    = |ras_q;
   assign ref_cyc = &ras_q;  // only a refresh strobes every row

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ras_q  <= '0;
         cas_q  <= '0;
         asel_q <= 1'b0;
         cnt_q  <= '0;
      end else if (!mem_cmd) begin
         // command gone, drop everything
         ras_q  <= '0;
         cas_q  <= '0;
         asel_q <= 1'b0;
         cnt_q  <= '0;
      end else if (!busy) begin
         if (start) begin
            ras_q <= refresh ? '1 : bank_oh;
            cnt_q <= CNT_W'(1);
         end
      end else begin
         if (cnt_q != CNT_W'(`PC_CAS_DELAY))
            cnt_q <= cnt_q + 1'b1;
         if (cnt_q == CNT_W'(`PC_ASEL_DELAY))
            asel_q <= 1'b1;  // switch ram address mux to column
         if (cnt_q == CNT_W'(`PC_CAS_DELAY) && !ref_cyc)
            cas_q <= ras_q;  // same bank as the row strobe
      end
   end

   assign ram_strb_o.ras      = ras_q;
   assign ram_strb_o.cas      = cas_q;
   assign ram_strb_o.addr_sel = asel_q;

endmodule

// File: rtl/nmi_ctrl.sv
// ####################
// nmi_ctrl
// ram parity generate and check, error latches and the nmi mask
// ####################
`timescale 1ns/10ps
`include "pc_glue_defines.svh"

module nmi_ctrl
   import pc_glue_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_n,
   input  bus_strb_t             bus_i,
   input  logic                  ram_sel_i,
   input  logic                  wr_nmi_i,
   input  logic [`PC_DATA_W-1:0] md_i,
   input  logic                  mdp_i,
   input  logic                  enb_ram_pck_n_i,
   input  logic                  io_ch_ck_n_i,
   input  logic                  enable_io_ck_n_i,
   output logic                  mdp_o,
   output logic                  pck_o,
   output logic                  io_ck_o,
   output logic                  nmi_o
);

   logic ram_rd;
   logic ram_wr;
   logic par_err;
   logic pck_q;
   logic io_ck_q;
   logic mask_q;

   assign ram_rd = bus_i.memr & ram_sel_i;
   assign ram_wr = bus_i.memw & ram_sel_i;

   // odd parity over data plus parity bit
   assign mdp_o   = ram_wr & ~(^md_i);
   assign par_err = ~(^{md_i, mdp_i});  // even count of ones is an error

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         pck_q   <= 1'b0;
         io_ck_q <= 1'b0;
         mask_q  <= 1'b0;
      end else begin
         if (enb_ram_pck_n_i)
            pck_q <= 1'b0;
         else if (ram_rd && par_err)
            pck_q <= 1'b1;

         // i/o channel check from an adapter card
         if (enable_io_ck_n_i)
            io_ck_q <= 1'b0;
         else if (!io_ch_ck_n_i)
            io_ck_q <= 1'b1;

         if (wr_nmi_i)
            mask_q <= md_i[7];  // port 0a0h, bit 7 allows nmi
      end
   end

   assign pck_o   = pck_q;
   assign io_ck_o = io_ck_q;
   assign nmi_o   = mask_q & (pck_q | io_ck_q);

endmodule

// File: rtl/pc_glue_defines.svh
// ####################
// pc glue defines
// bus widths, i/o port block numbers and ram strobe delays
// ####################
`ifndef PC_GLUE_DEFINES_SVH
`define PC_GLUE_DEFINES_SVH

// bus widths
`define PC_ADDR_W     20
`define PC_IO_ADDR_W  10
`define PC_DATA_W     8

`define PC_RAM_BANKS  4   // 64k each below 256k
`define PC_ROM_SELS   8   // 8k sockets in the f0000 segment

// i/o port blocks, picked by port address bits 7 to 5
`define PC_IO_DMA     3'd0  // 8237 at 000h
`define PC_IO_INTR    3'd1  // 8259 at 020h
`define PC_IO_TC      3'd2  // 8253 at 040h
`define PC_IO_PPI     3'd3  // 8255 at 060h
`define PC_IO_DMA_PG  3'd4  // page register at 080h
`define PC_IO_NMI     3'd5  // nmi mask at 0a0h

// ram strobe sequence, in clk cycles after ras
`define PC_CAS_DELAY  2
`define PC_ASEL_DELAY 1

`endif

// File: rtl/pc_glue_pkg.sv
// ####################
// pc glue package
// struct types for bus commands, chip selects and ram strobes
// ####################
`include "pc_glue_defines.svh"

package pc_glue_pkg;

   // current bus command, active high here
   // (the board carries these as ior_n, iow_n, memr_n, memw_n)
   typedef struct packed {
      logic ior;
      logic iow;
      logic memr;
      logic memw;
   } bus_strb_t;

   // support chip selects and register write strobes
   typedef struct packed {
      logic dma;        // 8237
      logic intr;       // 8259
      logic tc;         // 8253
      logic ppi;        // 8255
      logic wr_dma_pg;  // dma page register write
      logic wr_nmi;     // nmi mask register write
   } io_sel_t;

   // dynamic ram strobes for all banks
   typedef struct packed {
      logic [`PC_RAM_BANKS-1:0] ras;
      logic [`PC_RAM_BANKS-1:0] cas;
      logic                     addr_sel;  // row/column mux select
   } ram_strb_t;

endpackage

// File: rtl/pc_glue_top.sv
// ####################
// pc_glue_top
// system board glue: port and memory decode, dma hold, nmi logic
// ####################
`timescale 1ns/10ps
`include "pc_glue_defines.svh"

module pc_glue_top
   import pc_glue_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset_n,
   input  logic [`PC_ADDR_W-1:0]   addr_i,
   input  bus_strb_t               bus_i,
   input  logic                    aen_i,
   input  logic                    dack0_i,
   input  logic [2:0]              s_n_i,
   input  logic                    lock_n_i,
   input  logic                    hrq_i,
   input  logic [`PC_DATA_W-1:0]   md_i,
   input  logic                    mdp_i,
   input  logic                    io_ch_ck_n_i,
   input  logic                    enb_ram_pck_n_i,   // from ppi port b bit 4
   input  logic                    enable_io_ck_n_i,  // ppi port b bit 5
   output io_sel_t                 io_sel_o,
   output logic [`PC_ROM_SELS-1:0] rom_cs_n_o,
   output logic                    ram_sel_o,
   output ram_strb_t               ram_strb_o,
   output logic                    holda_o,
   output logic                    aen_brd_o,
   output logic                    dma_aen_o,
   output logic                    mdp_o,
   output logic                    pck_o,
   output logic                    io_ck_o,
   output logic                    nmi_o
);

   io_decode io_decode_inst (
      .io_addr_i (addr_i[`PC_IO_ADDR_W-1:0]),  // ports use the low address bits
      .bus_i     (bus_i),
      .aen_i     (aen_i),
      .io_sel_o  (io_sel_o)
   );

   mem_decode mem_decode_inst (
      .clk        (clk),
      .reset_n    (reset_n),
      .addr_i     (addr_i),
      .bus_i      (bus_i),
      .dack0_i    (dack0_i),
      .rom_cs_n_o (rom_cs_n_o),
      .ram_sel_o  (ram_sel_o),
      .ram_strb_o (ram_strb_o)
   );

   dma_arbiter dma_arbiter_inst (
      .clk       (clk),
      .reset_n   (reset_n),
      .s_n_i     (s_n_i),
      .lock_n_i  (lock_n_i),
      .hrq_i     (hrq_i),
      .holda_o   (holda_o),
      .aen_brd_o (aen_brd_o),
      .dma_aen_o (dma_aen_o)
   );

   nmi_ctrl nmi_ctrl_inst (
      .clk              (clk),
      .reset_n          (reset_n),
      .bus_i            (bus_i),
      .ram_sel_i        (ram_sel_o),
      .wr_nmi_i         (io_sel_o.wr_nmi),
      .md_i             (md_i),
      .mdp_i            (mdp_i),
      .enb_ram_pck_n_i  (enb_ram_pck_n_i),
      .io_ch_ck_n_i     (io_ch_ck_n_i),
      .enable_io_ck_n_i (enable_io_ck_n_i),
      .mdp_o            (mdp_o),
      .pck_o            (pck_o),
      .io_ck_o          (io_ck_o),
      .nmi_o            (nmi_o)
   );

endmodule

// File: sources.f
+incdir+rtl
rtl/pc_glue_pkg.sv
rtl/io_decode.sv
rtl/mem_decode.sv
rtl/dma_arbiter.sv
rtl/nmi_ctrl.sv
rtl/pc_glue_top.sv
test/pc_glue_assert.sv
test/tb_pc_glue.sv

// File: test/pc_glue_assert.sv
// ####################
// pc glue checker
// concurrent assertions on decode, ram strobes, dma hold and nmi
// ####################
`timescale 1ns/10ps
`include "pc_glue_defines.svh"

module pc_glue_assert
   import pc_glue_pkg::*;
(
   input logic                    clk,
   input logic                    reset_n,
   input logic [`PC_ADDR_W-1:0]   addr_i,
   input bus_strb_t               bus_i,
   input logic                    aen_i,
   input logic                    dack0_i,
   input logic [2:0]              s_n_i,
   input logic                    lock_n_i,
   input logic                    hrq_i,
   input logic [`PC_DATA_W-1:0]   md_i,
   input logic                    mdp_i,
   input logic                    io_ch_ck_n_i,
   input logic                    enb_ram_pck_n_i,
   input logic                    enable_io_ck_n_i,
   input io_sel_t                 io_sel_o,
   input logic [`PC_ROM_SELS-1:0] rom_cs_n_o,
   input logic                    ram_sel_o,
   input ram_strb_t               ram_strb_o,
   input logic                    holda_o,
   input logic                    aen_brd_o,
   input logic                    dma_aen_o,
   input logic                    mdp_o,
   input logic                    pck_o,
   input logic                    io_ck_o,
   input logic                    nmi_o
);

   int         err_cnt = 0;  // failed checks so far
   logic       io_ok;
   logic [2:0] io_blk;
   logic       rom_hit;
   logic       ram_hit;
   logic       mem_cmd;
   logic       bus_idle;
   logic       mask_exp;
   logic [1:0] bank_idx;

   assign io_ok    = !aen_i && (addr_i[`PC_IO_ADDR_W-1:8] == '0);
   assign io_blk   = addr_i[7:5];
   assign rom_hit  = &addr_i[19:16];
   assign ram_hit  = (addr_i[19:18] == 2'b00) && !dack0_i;
   assign mem_cmd  = bus_i.memr || bus_i.memw;
   assign bus_idle = (&s_n_i) && lock_n_i;
   assign bank_idx = addr_i[17:16];

   // expected mask, loaded from data bit 7 on a port 0a0h write
   always_ff @(posedge clk) begin
      if (!reset_n)
         mask_exp <= 1'b0;
      else if (io_ok && io_blk == `PC_IO_NMI && bus_i.iow)
         mask_exp <= md_i[7];
   end

   function automatic void flag_failure(input string what);
      err_cnt++;
      $error("%s", what);
   endfunction

   a_reset: assert property (@(posedge clk) !reset_n |=> ram_strb_o == '0 && !holda_o &&
      !aen_brd_o && !dma_aen_o && !pck_o && !io_ck_o && !nmi_o)
      else flag_failure("outputs not low after reset");

   a_io_sel: assert property (@(posedge clk) disable iff (!reset_n)
      io_sel_o.dma == (io_ok && io_blk == `PC_IO_DMA) &&
      io_sel_o.intr == (io_ok && io_blk == `PC_IO_INTR) &&
      io_sel_o.tc == (io_ok && io_blk == `PC_IO_TC) &&
      io_sel_o.ppi == (io_ok && io_blk == `PC_IO_PPI))
      else flag_failure("wrong chip select for the port address");
   a_io_wr: assert property (@(posedge clk) disable iff (!reset_n)
      io_sel_o.wr_nmi == (io_ok && io_blk == `PC_IO_NMI && bus_i.iow) &&
      io_sel_o.wr_dma_pg == (io_ok && io_blk == `PC_IO_DMA_PG && bus_i.iow))
      else flag_failure("wrong register write strobe");

   a_rom: assert property (@(posedge clk) disable iff (!reset_n)
      (rom_hit && bus_i.memr) ? ($onehot(~rom_cs_n_o) && !rom_cs_n_o[addr_i[15:13]]) :
      (rom_cs_n_o == '1))
      else flag_failure("wrong rom chip select");
   a_ram_sel: assert property (@(posedge clk) disable iff (!reset_n) ram_sel_o == ram_hit)
      else flag_failure("wrong ram select");

   // ras, then address select, then cas on the same bank
   a_ras: assert property (@(posedge clk) disable iff (!reset_n)
      mem_cmd && ram_hit && ram_strb_o.ras == '0 |=> $onehot(ram_strb_o.ras) &&
      ram_strb_o.ras[$past(bank_idx)] && ram_strb_o.cas == '0 && !ram_strb_o.addr_sel)
      else flag_failure("ras not on the addressed bank");
   a_asel: assert property (@(posedge clk) disable iff (!reset_n)
      mem_cmd && ram_hit && ram_strb_o.ras == '0 ##1 mem_cmd[*`PC_ASEL_DELAY] |=>
      ram_strb_o.addr_sel && ram_strb_o.cas == '0)
      else flag_failure("address select late or cas early");
   a_cas: assert property (@(posedge clk) disable iff (!reset_n)
      mem_cmd && ram_hit && ram_strb_o.ras == '0 ##1 mem_cmd[*`PC_CAS_DELAY] |=>
      $onehot(ram_strb_o.cas) && ram_strb_o.cas[$past(bank_idx, `PC_CAS_DELAY + 1)])
      else flag_failure("cas missing or on the wrong bank");
   a_drop: assert property (@(posedge clk) disable iff (!reset_n)
      !mem_cmd |=> ram_strb_o == '0)
      else flag_failure("ram strobes held after the command ended");

   a_refresh: assert property (@(posedge clk) disable iff (!reset_n)
      bus_i.memr && dack0_i && ram_strb_o.ras == '0 |=> ram_strb_o.ras == '1)
      else flag_failure("refresh did not strobe every row");
   a_ref_cas: assert property (@(posedge clk) disable iff (!reset_n)
      ram_strb_o.ras == '1 |-> ram_strb_o.cas == '0)
      else flag_failure("cas during refresh");

   a_grant: assert property (@(posedge clk) disable iff (!reset_n)
      hrq_i && bus_idle ##1 hrq_i |=> holda_o)
      else flag_failure("hold not granted on an idle bus");
   a_no_grant: assert property (@(posedge clk) disable iff (!reset_n)
      !holda_o && !$past(hrq_i && bus_idle) |=> !holda_o)
      else flag_failure("hold granted while the cpu bus was busy");
   a_release: assert property (@(posedge clk) disable iff (!reset_n) !hrq_i |=> !holda_o)
      else flag_failure("hold kept after the request dropped");
   a_stage: assert property (@(posedge clk) disable iff (!reset_n)
      aen_brd_o == $past(holda_o) && dma_aen_o == $past(aen_brd_o))
      else flag_failure("address enables out of order");

   a_par_gen: assert property (@(posedge clk) disable iff (!reset_n)
      bus_i.memw && ram_hit |-> ^{md_i, mdp_o})
      else flag_failure("generated parity not odd");
   a_pck_set: assert property (@(posedge clk) disable iff (!reset_n)
      bus_i.memr && ram_hit && !enb_ram_pck_n_i && !(^{md_i, mdp_i}) |=> pck_o)
      else flag_failure("parity error not latched");
   a_pck_clr: assert property (@(posedge clk) disable iff (!reset_n)
      enb_ram_pck_n_i |=> !pck_o)
      else flag_failure("parity latch not cleared");
   a_io_ck_set: assert property (@(posedge clk) disable iff (!reset_n)
      !io_ch_ck_n_i && !enable_io_ck_n_i |=> io_ck_o)
      else flag_failure("channel check not latched");
   a_io_ck_clr: assert property (@(posedge clk) disable iff (!reset_n)
      enable_io_ck_n_i |=> !io_ck_o)
      else flag_failure("channel check latch not cleared");
   a_nmi: assert property (@(posedge clk) disable iff (!reset_n)
      nmi_o == (mask_exp && (pck_o || io_ck_o)))
      else flag_failure("nmi does not follow mask and latches");

endmodule

bind pc_glue_top pc_glue_assert pc_glue_assert_inst (.*);

// File: test/tb_pc_glue.sv
// ####################
// pc glue testbench
// random port, memory, dma and nmi traffic into the glue top,
// the bound checker compares
// ####################
`timescale 1ns/10ps
`include "pc_glue_defines.svh"

module tb_pc_glue
   import pc_glue_pkg::*;
();

   localparam int TIMEOUT = 50;  // cycles allowed per wait

   logic                    clk;
   logic                    reset_n;
   logic [`PC_ADDR_W-1:0]   addr_i;
   bus_strb_t               bus_i;
   logic                    aen_i;
   logic                    dack0_i;
   logic [2:0]              s_n_i;
   logic                    lock_n_i;
   logic                    hrq_i;
   logic [`PC_DATA_W-1:0]   md_i;
   logic                    mdp_i;
   logic                    io_ch_ck_n_i;
   logic                    enb_ram_pck_n_i;
   logic                    enable_io_ck_n_i;
   io_sel_t                 io_sel_o;
   logic [`PC_ROM_SELS-1:0] rom_cs_n_o;
   logic                    ram_sel_o;
   ram_strb_t               ram_strb_o;
   logic                    holda_o;
   logic                    aen_brd_o;
   logic                    dma_aen_o;
   logic                    mdp_o;
   logic                    pck_o;
   logic                    io_ck_o;
   logic                    nmi_o;
   logic [31:0]             lfsr_q;

   pc_glue_top pc_glue_top_inst (.*);

   always #2 clk = ~clk;  // 4 ns period

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_q[0]};
         lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
      end
      return v;
   endfunction

   function automatic logic probe(input string what);
      case (what)
         "holda":   return holda_o;
         "dma_aen": return dma_aen_o;
         "ras":     return |ram_strb_o.ras;
         "pck":     return pck_o;
         default:   return io_ck_o;
      endcase
   endfunction

   task automatic cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic wait_level(input string what, input logic level);
      int n;
      n = 0;
      while (probe(what) !== level && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (probe(what) !== level) begin
         $display("timed out waiting for %s to go to %0b", what, level);
         $display("TEST FAIL");
         $fatal(1, "wait timeout");
      end
   endtask

   task automatic idle_bus();
      bus_i = '0;
      dack0_i = 1'b0;
   endtask

   // port 0a0h write, bit 7 allows nmi
   task automatic write_mask(input logic allow);
      addr_i = 20'h000a0;
      md_i = {allow, 7'h00};
      bus_i.iow = 1'b1;
      cycles(1);
      idle_bus();
   endtask

   // stop at the first checker failure
   always @(negedge clk) begin
      if (pc_glue_top_inst.pc_glue_assert_inst.err_cnt != 0) begin
         $display("ERROR @ %0t ns: checker saw a wrong value", $time);
         $display("TEST FAIL");
         $fatal(1, "assertion failure");
      end
   end

   initial begin
      clk = 1'b0;
      lfsr_q = 32'ha039;
      reset_n = 1'b0;
      addr_i = '0;
      bus_i = '0;
      aen_i = 1'b0;
      dack0_i = 1'b0;
      s_n_i = 3'b111;
      lock_n_i = 1'b1;
      hrq_i = 1'b0;
      md_i = '0;
      mdp_i = 1'b0;
      io_ch_ck_n_i = 1'b1;
      enb_ram_pck_n_i = 1'b1;
      enable_io_ck_n_i = 1'b1;
      cycles(4);
      reset_n = 1'b1;

      // port decode, now and then with upper bits or aen set
      repeat (40) begin
         addr_i = 20'(rand_bits(8));
         if (rand_bits(2) == 0)
            addr_i[9:8] = 2'(rand_bits(2));
         aen_i = (rand_bits(3) == 0);
         bus_i.iow = 1'(rand_bits(1));
         bus_i.ior = ~bus_i.iow;
         md_i = 8'(rand_bits(8));
         cycles(1);
      end
      idle_bus();
      aen_i = 1'b0;

      repeat (16) begin
         addr_i = {4'hf, 16'(rand_bits(16))};  // rom segment reads
         bus_i.memr = 1'b1;
         cycles(1);
      end
      idle_bus();

      // ram reads and writes with good parity
      repeat (8) begin
         addr_i = 20'(rand_bits(18));
         md_i = 8'(rand_bits(8));
         mdp_i = ~(^md_i);
         if (1'(rand_bits(1)))
            bus_i.memw = 1'b1;
         else
            bus_i.memr = 1'b1;
         wait_level("ras", 1'b1);
         cycles(`PC_CAS_DELAY + 1);
         idle_bus();
         cycles(1);
      end

      dack0_i = 1'b1;  // refresh channel
      repeat (3) begin
         addr_i = 20'(rand_bits(20));
         bus_i.memr = 1'b1;
         wait_level("ras", 1'b1);
         cycles(`PC_CAS_DELAY + 1);
         bus_i.memr = 1'b0;
         cycles(1);
      end
      idle_bus();

      // dma hold on an idle bus, then release
      hrq_i = 1'b1;
      wait_level("holda", 1'b1);
      wait_level("dma_aen", 1'b1);
      hrq_i = 1'b0;
      wait_level("dma_aen", 1'b0);
      s_n_i = {1'b0, 2'(rand_bits(2))};  // busy status
      hrq_i = 1'b1;
      cycles(6);
      s_n_i = 3'b111;
      lock_n_i = 1'b0;
      cycles(6);
      hrq_i = 1'b0;
      lock_n_i = 1'b1;
      cycles(2);

      // parity errors, nmi allowed on the first pass only
      enb_ram_pck_n_i = 1'b0;
      for (int pass = 0; pass < 2; pass++) begin
         write_mask(pass == 0);
         addr_i = 20'(rand_bits(18));
         md_i = 8'(rand_bits(8));
         mdp_i = ^md_i;  // even count of ones
         bus_i.memr = 1'b1;
         wait_level("pck", 1'b1);
         cycles(2);
         idle_bus();
         enb_ram_pck_n_i = 1'b1;
         wait_level("pck", 1'b0);
         enb_ram_pck_n_i = 1'b0;
      end
      enb_ram_pck_n_i = 1'b1;

      write_mask(1'b1);
      enable_io_ck_n_i = 1'b0;
      io_ch_ck_n_i = 1'b0;
      wait_level("io_ck", 1'b1);
      io_ch_ck_n_i = 1'b1;
      cycles(2);
      enable_io_ck_n_i = 1'b1;
      wait_level("io_ck", 1'b0);
      cycles(4);

      if (pc_glue_top_inst.pc_glue_assert_inst.err_cnt == 0) begin
         $display("TEST PASS");
         $finish;
      end else begin
         $display("TEST FAIL");
         $fatal(1, "checker reported failures");
      end
   end

endmodule
